// File: scr_settings.svh
/*
  Raster size, slot length and register map bases for the scroll layers.
  Include it wherever one of these sizes is needed.
*/
`ifndef SCR_SETTINGS_SVH
`define SCR_SETTINGS_SVH

// Raster, small enough for quick simulation
`define SCR_HACTIVE 16
`define SCR_HTOTAL 20
`define SCR_VACTIVE 8
`define SCR_VTOTAL 10

// Clocks spent on one pixel
`define SCR_SLOT 8

// Layer count and register map
`define SCR_LAYERS 6
`define SCR_ATTR_BASE 16
`define SCR_PAL_BASE 24

`endif

// File: scr_pkg.sv
/*
  Shared types for the scroll subsystem. Modules take them by a
  wildcard import in their header.
*/
`default_nettype none

`include "scr_settings.svh"

package scr_pkg;

  // Attribute view of a register byte
  typedef struct packed {
    logic [3:0] unused;
    logic       en;
    logic [2:0] prio;
  } layer_attr_t;

  // Each byte decodes either as scroll data or as a layer attribute
  typedef union packed {
    logic [7:0]  scroll;
    layer_attr_t attr;
  } mmr_byte_u;

  // Decoded layer configuration
  typedef struct packed {
    logic [3:0][15:0]             hscr;
    logic [3:0][15:0]             vscr;
    logic [`SCR_LAYERS-1:0][2:0]  prio;
    logic [`SCR_LAYERS-1:0]       enb;
    logic [`SCR_LAYERS-1:0][2:0]  pal;
  } scr_cfg_t;

  // One scrolled pixel request to the tile memory
  typedef struct packed {
    logic [2:0] layer;
    logic [8:0] x;
    logic [8:0] y;
  } fetch_req_t;

  // Pixel back from the tile memory, zero is transparent
  typedef struct packed {
    logic [2:0] layer;
    logic [3:0] pixel;
  } layer_pix_t;

  // Resolved screen pixel
  typedef struct packed {
    logic [8:0] x;
    logic [8:0] y;
    logic       opaque;
    logic [6:0] color;
  } color_out_t;

endpackage

`default_nettype wire

// File: scr_mmr.sv
/*
  CPU register block with 32 bytes of scroll, attribute and palette data.
  Decodes the bytes into the layer configuration used by fetch and mixer.
*/
`default_nettype none

`include "scr_settings.svh"

module scr_mmr import scr_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       cs,
  input  logic [4:0] addr,
  input  logic       rnw,
  input  logic [7:0] din,
  output logic [7:0] dout,
  output scr_cfg_t   cfg
);

  // Register array, one union per byte
  mmr_byte_u regs [32];

  logic wr_en;

  assign wr_en = cs && !rnw;

  // Write port and readback
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
      dout <= '0;
    end else begin
      if (wr_en) begin
        regs[addr].scroll <= din;
      end
      // Written byte shows up on the next cycle
      if (wr_en) begin
        dout <= din;
      end else begin
        dout <= regs[addr].scroll;
      end
    end
  end

  // Scroll words, high byte first in the map
  for (genvar l = 0; l < 4; l++) begin : g_scroll
    assign cfg.hscr[l] = {regs[l*4+0].scroll, regs[l*4+1].scroll};
    assign cfg.vscr[l] = {regs[l*4+2].scroll, regs[l*4+3].scroll};
  end

  // Attribute and palette bytes, one per layer
  for (genvar l = 0; l < `SCR_LAYERS; l++) begin : g_attr
    assign cfg.prio[l] = regs[`SCR_ATTR_BASE + l].attr.prio;
    assign cfg.enb[l]  = regs[`SCR_ATTR_BASE + l].attr.en;
    // Only the low 3 bits select a bank
    assign cfg.pal[l]  = regs[`SCR_PAL_BASE + l].scroll[2:0];
  end

  // A floating chip select would corrupt the register file
  a_cs_known: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown(cs)
  ) else $error("scr_mmr: cs is unknown");

endmodule

`default_nettype wire

// File: video_timer.sv
/*
  Raster scan counters with the per-pixel slot timer.
  slot_start marks the first clock of each active pixel slot.
*/
`default_nettype none

`include "scr_settings.svh"

module video_timer (
  input  logic       clk,
  input  logic       rst,
  output logic [8:0] hpos,
  output logic [8:0] vpos,
  output logic       slot_start
);

  localparam int SW = $clog2(`SCR_SLOT);
  localparam logic [SW-1:0] SLOT_LAST = SW'(`SCR_SLOT - 1);
  localparam logic [8:0] H_LAST = 9'(`SCR_HTOTAL - 1);
  localparam logic [8:0] V_LAST = 9'(`SCR_VTOTAL - 1);
  localparam logic [8:0] H_ACT = 9'(`SCR_HACTIVE);
  localparam logic [8:0] V_ACT = 9'(`SCR_VACTIVE);

  logic [SW-1:0] slot_cnt;
  logic          active;

  // Clock count inside the current pixel
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      slot_cnt <= '0;
    end else if (slot_cnt == SLOT_LAST) begin
      slot_cnt <= '0;
    end else begin
      slot_cnt <= slot_cnt + 1'b1;
    end
  end

  // Pixel and line counters
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hpos <= '0;
      vpos <= '0;
    end else if (slot_cnt == SLOT_LAST) begin
      if (hpos == H_LAST) begin
        hpos <= '0;
        // New line, wrap at the end of the frame
        if (vpos == V_LAST) begin
          vpos <= '0;
        end else begin
          vpos <= vpos + 1'b1;
        end
      end else begin
        hpos <= hpos + 1'b1;
      end
    end
  end

  // Blanking suppresses slot starts
  assign active = (hpos < H_ACT) && (vpos < V_ACT);
  assign slot_start = active && (slot_cnt == '0);

  a_range: assert property (
    @(posedge clk) disable iff (rst)
    hpos <= H_LAST && vpos <= V_LAST
  ) else $error("video_timer: raster counter out of range");

endmodule

`default_nettype wire

// File: fetch_fsm.sv
/*
  Walks the six layers once per pixel slot and issues one scrolled
  pixel request per layer, then signals done to the mixer.
*/
`default_nettype none

`include "scr_settings.svh"

module fetch_fsm import scr_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  scr_cfg_t   cfg,
  input  logic [8:0] hpos,
  input  logic [8:0] vpos,
  input  logic       slot_start,
  output fetch_req_t req,
  output logic       req_valid,
  output logic       done,
  output logic [8:0] pos_x,
  output logic [8:0] pos_y
);

  localparam logic [1:0] S_IDLE   = 2'd0;
  localparam logic [1:0] S_FETCH  = 2'd1;
  localparam logic [1:0] S_FINISH = 2'd2;
  localparam logic [2:0] L_LAST   = 3'(`SCR_LAYERS - 1);

  logic [1:0] state;
  logic [2:0] lyr;

  // State and layer step
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= S_IDLE;
      lyr   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (slot_start) begin
            state <= S_FETCH;
            lyr   <= '0;
          end
        end
        S_FETCH: begin
          // One layer per clock
          if (lyr == L_LAST) begin
            state <= S_FINISH;
          end else begin
            lyr <= lyr + 1'b1;
          end
        end
        S_FINISH: begin
          state <= S_IDLE;
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Screen position held for the whole slot
  always_ff @(posedge clk) begin
    if (state == S_IDLE && slot_start) begin
      pos_x <= hpos;
      pos_y <= vpos;
    end
  end

  // Request address, layers 4 and 5 do not scroll
  always_comb begin
    req.layer = lyr;
    if (lyr < 3'd4) begin
      req.x = pos_x + cfg.hscr[lyr[1:0]][8:0];
      req.y = pos_y + cfg.vscr[lyr[1:0]][8:0];
    end else begin
      req.x = pos_x;
      req.y = pos_y;
    end
  end

  assign req_valid = (state == S_FETCH);
  assign done      = (state == S_FINISH);

  // A request burst is six back-to-back layers followed by done
  a_burst: assert property (
    @(posedge clk) disable iff (rst)
    $rose(req_valid) |-> req.layer == 3'd0 ##0 req_valid [*`SCR_LAYERS] ##1 (done && !req_valid)
  ) else $error("fetch_fsm: malformed request burst");

  a_no_overlap: assert property (
    @(posedge clk) disable iff (rst)
    slot_start |-> state == S_IDLE
  ) else $error("fetch_fsm: slot_start while busy");

endmodule

`default_nettype wire

// File: layer_mixer.sv
/*
  Collects the returned layer pixels of one slot and resolves them by
  enable and priority into one registered output color.
*/
`default_nettype none

`include "scr_settings.svh"

module layer_mixer import scr_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  scr_cfg_t   cfg,
  input  layer_pix_t pix,
  input  logic       pix_valid,
  input  logic       done,
  input  logic [8:0] pos_x,
  input  logic [8:0] pos_y,
  output color_out_t color,
  output logic       color_valid
);

  // Pixels gathered so far in this slot
  logic [`SCR_LAYERS-1:0][3:0] stage_pix;
  // Staged pixels merged with the one arriving now
  logic [`SCR_LAYERS-1:0][3:0] cur_pix;
  logic       found;
  logic [2:0] win;
  logic [2:0] best_prio;

  // Staging, emptied once the slot resolves
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stage_pix <= '0;
    end else if (done) begin
      stage_pix <= '0;
    end else if (pix_valid) begin
      stage_pix[pix.layer] <= pix.pixel;
    end
  end

  always_comb begin
    for (int l = 0; l < `SCR_LAYERS; l++) begin
      if (pix_valid && pix.layer == 3'(l)) begin
        cur_pix[l] = pix.pixel;
      end else begin
        cur_pix[l] = stage_pix[l];
      end
    end
  end

  // Highest priority wins, equal priority goes to the higher layer
  always_comb begin
    found     = 1'b0;
    win       = '0;
    best_prio = '0;
    for (int l = 0; l < `SCR_LAYERS; l++) begin
      if (cfg.enb[l] && cur_pix[l] != 4'd0 && (!found || cfg.prio[l] >= best_prio)) begin
        found     = 1'b1;
        win       = 3'(l);
        best_prio = cfg.prio[l];
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      color_valid <= 1'b0;
    end else begin
      color_valid <= done;
    end
  end

  // Output pixel, bank over pixel value
  always_ff @(posedge clk) begin
    if (done) begin
      color.x      <= pos_x;
      color.y      <= pos_y;
      color.opaque <= found;
      color.color  <= found ? {cfg.pal[win], cur_pix[win]} : 7'd0;
    end
  end

  a_layer_tag: assert property (
    @(posedge clk) disable iff (rst)
    pix_valid |-> pix.layer < 3'(`SCR_LAYERS)
  ) else $error("layer_mixer: layer tag out of range");

  // Last pixel of the slot lands together with done
  a_done_pix: assert property (
    @(posedge clk) disable iff (rst)
    done |-> pix_valid
  ) else $error("layer_mixer: done without pixel");

endmodule

`default_nettype wire

// File: scroll_top.sv
/*
  Scroll layer subsystem top. CPU register port in, tile pixel requests
  out and back, one resolved color per active pixel.
*/
`default_nettype none

module scroll_top import scr_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // CPU port
  input  logic       cs,
  input  logic [4:0] addr,
  input  logic       rnw,
  input  logic [7:0] din,
  output logic [7:0] dout,
  // Tile memory
  output fetch_req_t req,
  output logic       req_valid,
  input  layer_pix_t pix,
  input  logic       pix_valid,
  // Video out
  output color_out_t color,
  output logic       color_valid
);

  scr_cfg_t   cfg;
  logic [8:0] hpos;
  logic [8:0] vpos;
  logic       slot_start;
  logic       done;
  logic [8:0] pos_x;
  logic [8:0] pos_y;

  scr_mmr scr_mmr_i (
    .clk  (clk),
    .rst  (rst),
    .cs   (cs),
    .addr (addr),
    .rnw  (rnw),
    .din  (din),
    .dout (dout),
    .cfg  (cfg)
  );

  video_timer video_timer_i (
    .clk        (clk),
    .rst        (rst),
    .hpos       (hpos),
    .vpos       (vpos),
    .slot_start (slot_start)
  );

  fetch_fsm fetch_fsm_i (
    .clk        (clk),
    .rst        (rst),
    .cfg        (cfg),
    .hpos       (hpos),
    .vpos       (vpos),
    .slot_start (slot_start),
    .req        (req),
    .req_valid  (req_valid),
    .done       (done),
    .pos_x      (pos_x),
    .pos_y      (pos_y)
  );

  // Resolves one slot while the next one is fetched
  layer_mixer layer_mixer_i (
    .clk         (clk),
    .rst         (rst),
    .cfg         (cfg),
    .pix         (pix),
    .pix_valid   (pix_valid),
    .done        (done),
    .pos_x       (pos_x),
    .pos_y       (pos_y),
    .color       (color),
    .color_valid (color_valid)
  );

endmodule

`default_nettype wire

// File: scroll_tb.sv
/*
  Testbench for the scroll layer top. Models the tile memory, keeps a
  shadow of the registers and checks every output with assertions.
*/
`default_nettype none

`include "scr_settings.svh"

module scroll_tb import scr_pkg::*; ();

  localparam int NPIX = `SCR_HACTIVE * `SCR_VACTIVE;
  localparam int NTESTS = 6;
  localparam longint FRAME_T = `SCR_VTOTAL * `SCR_HTOTAL * `SCR_SLOT * 100;

  logic       clk;
  logic       rst;
  logic       cs;
  logic       rnw;
  logic [4:0] addr;
  logic [7:0] din;
  logic [7:0] dout;
  fetch_req_t req;
  logic       req_valid;
  layer_pix_t pix;
  logic       pix_valid;
  color_out_t color;
  logic       color_valid;

  // Shadow of the register block
  logic [7:0]  shadow [32];
  logic [7:0]  rd_exp;
  logic [7:0]  rd_exp_q;
  logic [31:0] lfsr;
  logic        chk_on;
  string       test_name;
  int          err_cnt;
  int          err_start;
  int          test_fail;
  // Tile memory answer, one clock behind the request
  logic        req_v_q;
  layer_pix_t  pix_q;
  // Raster order tracking
  logic [8:0]  exp_x;
  logic [8:0]  exp_y;
  logic [8:0]  vpos_q;
  int          pix_cnt;

  scroll_top scroll_top_i (
    .clk         (clk),
    .rst         (rst),
    .cs          (cs),
    .addr        (addr),
    .rnw         (rnw),
    .din         (din),
    .dout        (dout),
    .req         (req),
    .req_valid   (req_valid),
    .pix         (pix),
    .pix_valid   (pix_valid),
    .color       (color),
    .color_valid (color_valid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Tile memory content
  function automatic logic [3:0] tile_pix(int l, logic [8:0] x, logic [8:0] y);
    logic [8:0] v;
    v = x ^ y ^ 9'(3 * l);
    return v[3:0];
  endfunction

  // Pixel a layer shows at a screen position, only layers 0 to 3 scroll
  function automatic logic [3:0] layer_pix(int l, logic [8:0] x, logic [8:0] y);
    logic [8:0] sx;
    logic [8:0] sy;
    sx = x;
    sy = y;
    if (l < 4) begin
      sx = x + {shadow[l*4][0], shadow[l*4+1]};
      sy = y + {shadow[l*4+2][0], shadow[l*4+3]};
    end
    return tile_pix(l, sx, sy);
  endfunction

  // Search from the top layer down, so a tie keeps the higher layer
  function automatic int ref_winner(logic [8:0] x, logic [8:0] y);
    int w;
    logic [7:0] attr;
    w = -1;
    for (int l = `SCR_LAYERS - 1; l >= 0; l--) begin
      attr = shadow[`SCR_ATTR_BASE + l];
      if (attr[3] && layer_pix(l, x, y) != 4'd0 &&
          (w < 0 || attr[2:0] > shadow[`SCR_ATTR_BASE + w][2:0])) begin
        w = l;
      end
    end
    return w;
  endfunction

  function automatic color_out_t ref_color(logic [8:0] x, logic [8:0] y);
    color_out_t c;
    int w;
    w = ref_winner(x, y);
    c.x = x;
    c.y = y;
    c.opaque = (w >= 0);
    c.color = '0;
    if (w >= 0) begin
      c.color = {shadow[`SCR_PAL_BASE + w][2:0], layer_pix(w, x, y)};
    end
    return c;
  endfunction

  task automatic flag_mismatch(logic [31:0] exp, logic [31:0] act);
    $display("ERROR %s: expected %h, actual %h", test_name, exp, act);
    err_cnt++;
  endtask

  task automatic flag_failure(string what);
    $display("%s: %s", test_name, what);
    err_cnt++;
  endtask

  // Tile memory model
  always @(posedge clk) begin
    #10;
    pix_valid = req_v_q;
    pix = pix_q;
    req_v_q = req_valid;
    pix_q.layer = req.layer;
    pix_q.pixel = tile_pix(int'(req.layer), req.x, req.y);
  end

  // Next expected raster position and pulses per frame
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      exp_x    <= '0;
      exp_y    <= '0;
      vpos_q   <= '0;
      pix_cnt  <= 0;
      rd_exp_q <= '0;
    end else begin
      vpos_q   <= scroll_top_i.vpos;
      rd_exp_q <= rd_exp;
      if (scroll_top_i.vpos == 9'd0 && vpos_q != 9'd0) begin
        pix_cnt <= 0;
      end else if (color_valid) begin
        pix_cnt <= pix_cnt + 1;
      end
      if (color_valid) begin
        if (exp_x == 9'(`SCR_HACTIVE - 1)) begin
          exp_x <= '0;
          exp_y <= (exp_y == 9'(`SCR_VACTIVE - 1)) ? 9'd0 : exp_y + 1'b1;
        end else begin
          exp_x <= exp_x + 1'b1;
        end
      end
    end
  end

  a_color: assert property (@(posedge clk) disable iff (rst)
    color_valid && chk_on |-> color == ref_color(color.x, color.y))
    else flag_mismatch(32'(ref_color($sampled(color.x), $sampled(color.y))),
                       32'($sampled(color)));

  // Reads and writes both show their byte on dout one cycle later
  a_readback: assert property (@(posedge clk) disable iff (rst)
    cs |=> dout == rd_exp_q)
    else flag_mismatch(32'($sampled(rd_exp_q)), 32'($sampled(dout)));

  a_latency: assert property (@(posedge clk) disable iff (rst)
    scroll_top_i.slot_start |-> ##8 color_valid)
    else flag_failure("no color 8 clocks after a slot start");

  a_order: assert property (@(posedge clk) disable iff (rst)
    color_valid |-> color.x == exp_x && color.y == exp_y)
    else flag_mismatch({$sampled(exp_y), $sampled(exp_x)},
                       {$sampled(color.y), $sampled(color.x)});

  // Frame boundary is the wrap of the line counter to zero
  a_frame: assert property (@(posedge clk) disable iff (rst)
    scroll_top_i.vpos == 9'd0 && vpos_q != 9'd0 |-> pix_cnt == NPIX)
    else flag_mismatch(NPIX, $sampled(pix_cnt));

  task automatic reg_write(logic [4:0] a, logic [7:0] d);
    cs = 1'b1;
    rnw = 1'b0;
    addr = a;
    din = d;
    shadow[a] = d;
    rd_exp = d;
    @(posedge clk);
    #10;
    cs = 1'b0;
    rnw = 1'b1;
  endtask

  task automatic reg_read(logic [4:0] a);
    cs = 1'b1;
    rnw = 1'b1;
    addr = a;
    rd_exp = shadow[a];
    @(posedge clk);
    #10;
    cs = 1'b0;
  endtask

  task automatic wait_colors(int n);
    repeat (n) begin
      @(posedge clk);
      while (!color_valid) begin
        @(posedge clk);
      end
    end
    #10;
  endtask

  // Skip the slots fetched across a register change
  task automatic settle();
    wait_colors(2);
    chk_on = 1'b1;
  endtask

  task automatic start_test(string name);
    test_name = name;
    err_start = err_cnt;
  endtask

  task automatic finish_test();
    if (err_cnt == err_start) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, err_cnt - err_start);
      test_fail++;
    end
  endtask

  initial begin
    rst = 1'b1;
    cs = 1'b0;
    rnw = 1'b1;
    addr = '0;
    din = '0;
    pix = '0;
    pix_valid = 1'b0;
    req_v_q = 1'b0;
    pix_q = '0;
    rd_exp = '0;
    lfsr = 32'hb4cc;
    chk_on = 1'b0;
    err_cnt = 0;
    err_start = 0;
    test_fail = 0;
    test_name = "reset";
    for (int a = 0; a < 32; a++) begin
      shadow[a] = '0;
    end
    repeat (2) @(posedge clk);
    #10;
    rst = 1'b0;

    // All layers disabled out of reset
    start_test("reset");
    chk_on = 1'b1;
    wait_colors(NPIX);
    finish_test();

    // Two passes, so the readback shows the last write
    start_test("readback");
    chk_on = 1'b0;
    repeat (2) begin
      for (int a = 0; a < 32; a++) begin
        reg_write(5'(a), 8'(rand_bits(8)));
      end
    end
    for (int a = 0; a < 32; a++) begin
      reg_read(5'(a));
    end
    @(posedge clk);
    #10;
    finish_test();

    // Layer 0 alone, random scroll
    start_test("scroll");
    chk_on = 1'b0;
    for (int l = 0; l < `SCR_LAYERS; l++) begin
      reg_write(5'(`SCR_ATTR_BASE + l), (l == 0) ? {5'b00001, 3'(rand_bits(3))} : 8'd0);
    end
    for (int i = 0; i < 4; i++) begin
      reg_write(5'(i), 8'(rand_bits(8)));
    end
    reg_write(5'(`SCR_PAL_BASE), 8'(rand_bits(8)));
    settle();
    wait_colors(NPIX);
    finish_test();

    // Random priorities and enables, ties included
    start_test("priority");
    chk_on = 1'b0;
    for (int l = 0; l < `SCR_LAYERS; l++) begin
      reg_write(5'(`SCR_ATTR_BASE + l), 8'(rand_bits(8)));
    end
    settle();
    wait_colors(NPIX);
    finish_test();

    // Every layer on, so each bank gets to win
    start_test("palette");
    chk_on = 1'b0;
    for (int l = 0; l < `SCR_LAYERS; l++) begin
      reg_write(5'(`SCR_ATTR_BASE + l), 8'(rand_bits(8)) | 8'h08);
      reg_write(5'(`SCR_PAL_BASE + l), 8'(rand_bits(8)));
    end
    settle();
    wait_colors(NPIX);
    finish_test();

    // Long enough to cross a frame boundary
    start_test("raster");
    wait_colors(2 * NPIX);
    finish_test();

    $display("tests %0d, failed %0d, errors %0d", NTESTS, test_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Three frames per test plus one spare
  initial begin
    #(NTESTS * 3 * FRAME_T + FRAME_T);
    $display("timeout, test %s did not finish in time", test_name);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
scr_pkg.sv
scr_mmr.sv
video_timer.sv
fetch_fsm.sv
layer_mixer.sv
scroll_top.sv
scroll_tb.sv
